// File: axi_lite_pkg.sv
package axi_lite_pkg;

  // Bus geometry of the AXI4-Lite slave port
  localparam int AXIL_DATA_WIDTH = 32;
  localparam int AXIL_STRB_WIDTH = AXIL_DATA_WIDTH / 8;  // One strobe bit per byte

  // One data word on the W or R channel
  typedef logic [AXIL_DATA_WIDTH-1:0] axil_data_t;

  // Write byte strobes, bit n enables byte n
  typedef logic [AXIL_STRB_WIDTH-1:0] axil_strb_t;

  // BRESP / RRESP encoding
  typedef logic [1:0] axil_resp_t;

  localparam axil_resp_t RESP_OKAY = 2'b00;

endpackage

// File: axil_read_channel.sv
`timescale 1ns/1ps

module axil_read_channel #(
  parameter int ADDR_WIDTH = regmap_pkg::DEFAULT_ADDR_WIDTH,
  localparam int IDX_W = ADDR_WIDTH - regmap_pkg::ADDR_LSB
) (
  input  logic                     S_AXI_ACLK,
  input  logic                     S_AXI_ARESETN,
  input  logic [ADDR_WIDTH-1:0]    s_axi_araddr,
  input  logic                     s_axi_arvalid,
  output logic                     s_axi_arready,
  output axi_lite_pkg::axil_data_t s_axi_rdata,
  output axi_lite_pkg::axil_resp_t s_axi_rresp,
  output logic                     s_axi_rvalid,
  input  logic                     s_axi_rready,
  input  axi_lite_pkg::axil_data_t rd_data,
  output logic [IDX_W-1:0]         rd_index
);

  import axi_lite_pkg::*;
  import regmap_pkg::*;

  logic             arready_q;
  logic             accept;
  logic             rd_strobe;
  logic [IDX_W-1:0] aridx_q;
  logic             rvalid_q;
  axil_data_t       rdata_q;

  // Hold off new reads while a response is stalled
  assign accept    = !arready_q && s_axi_arvalid && (!rvalid_q || s_axi_rready);
  assign rd_strobe = arready_q && s_axi_arvalid;

  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      arready_q <= 1'b0;
    end else begin
      arready_q <= accept;
    end
  end

  always_ff @(posedge S_AXI_ACLK) begin
    if (accept) begin
      aridx_q <= s_axi_araddr[ADDR_WIDTH-1:ADDR_LSB];
    end
  end

  assign rd_index = aridx_q;

  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      rvalid_q <= 1'b0;
    end else if (rd_strobe) begin
      rvalid_q <= 1'b1;
    end else if (s_axi_rready) begin
      rvalid_q <= 1'b0;
    end
  end

  always_ff @(posedge S_AXI_ACLK) begin
    if (rd_strobe) begin
      rdata_q <= rd_data;
    end
  end

  assign s_axi_arready = arready_q;
  assign s_axi_rvalid  = rvalid_q;
  assign s_axi_rdata   = rdata_q;
  assign s_axi_rresp   = RESP_OKAY;

  // Data must not move under a stalled response
  rdata_stable: assert property (
    @(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid && $stable(s_axi_rdata)
  ) else $error("RDATA changed while RVALID waited for RREADY");

endmodule

// File: axil_regbank.sv
`timescale 1ns/1ps

module axil_regbank #(
  parameter int ADDR_WIDTH = regmap_pkg::DEFAULT_ADDR_WIDTH
) (
  input  logic                     S_AXI_ACLK,
  input  logic                     S_AXI_ARESETN,
  input  logic [ADDR_WIDTH-1:0]    s_axi_awaddr,
  input  logic                     s_axi_awvalid,
  output logic                     s_axi_awready,
  input  axi_lite_pkg::axil_data_t s_axi_wdata,
  input  axi_lite_pkg::axil_strb_t s_axi_wstrb,
  input  logic                     s_axi_wvalid,
  output logic                     s_axi_wready,
  output axi_lite_pkg::axil_resp_t s_axi_bresp,
  output logic                     s_axi_bvalid,
  input  logic                     s_axi_bready,
  input  logic [ADDR_WIDTH-1:0]    s_axi_araddr,
  input  logic                     s_axi_arvalid,
  output logic                     s_axi_arready,
  output axi_lite_pkg::axil_data_t s_axi_rdata,
  output axi_lite_pkg::axil_resp_t s_axi_rresp,
  output logic                     s_axi_rvalid,
  input  logic                     s_axi_rready
);

  import axi_lite_pkg::*;
  import regmap_pkg::*;

  localparam int IDX_W = ADDR_WIDTH - ADDR_LSB;

  // Write channel to register file
  logic             wr_strobe;
  logic [IDX_W-1:0] wr_index;
  axil_data_t       wr_data;
  axil_strb_t       wr_strb;

  // Register file to read channel
  logic [IDX_W-1:0] rd_index;
  axil_data_t       rd_data;

  axil_write_channel #(.ADDR_WIDTH(ADDR_WIDTH)) u_write_channel (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .s_axi_awaddr  (s_axi_awaddr),
    .s_axi_awvalid (s_axi_awvalid),
    .s_axi_awready (s_axi_awready),
    .s_axi_wdata   (s_axi_wdata),
    .s_axi_wstrb   (s_axi_wstrb),
    .s_axi_wvalid  (s_axi_wvalid),
    .s_axi_wready  (s_axi_wready),
    .s_axi_bresp   (s_axi_bresp),
    .s_axi_bvalid  (s_axi_bvalid),
    .s_axi_bready  (s_axi_bready),
    .wr_strobe     (wr_strobe),
    .wr_index      (wr_index),
    .wr_data       (wr_data),
    .wr_strb       (wr_strb)
  );

  axil_regfile #(.ADDR_WIDTH(ADDR_WIDTH)) u_regfile (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .wr_strobe     (wr_strobe),
    .wr_index      (wr_index),
    .wr_data       (wr_data),
    .wr_strb       (wr_strb),
    .rd_index      (rd_index),
    .rd_data       (rd_data)
  );

  axil_read_channel #(.ADDR_WIDTH(ADDR_WIDTH)) u_read_channel (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .s_axi_araddr  (s_axi_araddr),
    .s_axi_arvalid (s_axi_arvalid),
    .s_axi_arready (s_axi_arready),
    .s_axi_rdata   (s_axi_rdata),
    .s_axi_rresp   (s_axi_rresp),
    .s_axi_rvalid  (s_axi_rvalid),
    .s_axi_rready  (s_axi_rready),
    .rd_data       (rd_data),
    .rd_index      (rd_index)
  );

endmodule

// File: axil_regfile.sv
`timescale 1ns/1ps

module axil_regfile #(
  parameter int ADDR_WIDTH = regmap_pkg::DEFAULT_ADDR_WIDTH,
  localparam int IDX_W = ADDR_WIDTH - regmap_pkg::ADDR_LSB
) (
  input  logic                     S_AXI_ACLK,
  input  logic                     S_AXI_ARESETN,
  input  logic                     wr_strobe,
  input  logic [IDX_W-1:0]         wr_index,
  input  axi_lite_pkg::axil_data_t wr_data,
  input  axi_lite_pkg::axil_strb_t wr_strb,
  input  logic [IDX_W-1:0]         rd_index,
  output axi_lite_pkg::axil_data_t rd_data
);

  import axi_lite_pkg::*;
  import regmap_pkg::*;

  localparam int NUM_REGS = 2 ** IDX_W;

  axil_data_t regs [NUM_REGS];

  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= REG_RESET_VALUE;
      end
    end else if (wr_strobe) begin
      // Only strobed bytes change
      for (int b = 0; b < AXIL_STRB_WIDTH; b++) begin
        if (wr_strb[b]) begin
          regs[wr_index][b*8 +: 8] <= wr_data[b*8 +: 8];
        end
      end
    end
  end

  assign rd_data = regs[rd_index];  // Sampled by the read channel

  // Index comes from the write channel's captured address
  wr_index_known: assert property (
    @(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    wr_strobe |-> !$isunknown(wr_index)
  ) else $error("Write strobe with unknown register index");

endmodule

// File: axil_write_channel.sv
`timescale 1ns/1ps

module axil_write_channel #(
  parameter int ADDR_WIDTH = regmap_pkg::DEFAULT_ADDR_WIDTH,
  localparam int IDX_W = ADDR_WIDTH - regmap_pkg::ADDR_LSB
) (
  input  logic                     S_AXI_ACLK,
  input  logic                     S_AXI_ARESETN,
  input  logic [ADDR_WIDTH-1:0]    s_axi_awaddr,
  input  logic                     s_axi_awvalid,
  output logic                     s_axi_awready,
  input  axi_lite_pkg::axil_data_t s_axi_wdata,
  input  axi_lite_pkg::axil_strb_t s_axi_wstrb,
  input  logic                     s_axi_wvalid,
  output logic                     s_axi_wready,
  output axi_lite_pkg::axil_resp_t s_axi_bresp,
  output logic                     s_axi_bvalid,
  input  logic                     s_axi_bready,
  output logic                     wr_strobe,
  output logic [IDX_W-1:0]         wr_index,
  output axi_lite_pkg::axil_data_t wr_data,
  output axi_lite_pkg::axil_strb_t wr_strb
);

  import axi_lite_pkg::*;
  import regmap_pkg::*;

  logic             aw_w_ready;  // Shared ready for AW and W
  logic             accept;
  logic [IDX_W-1:0] awidx_q;
  logic             bvalid_q;

  // Both channels present and room for the response
  assign accept = !aw_w_ready && s_axi_awvalid && s_axi_wvalid &&
                  (!bvalid_q || s_axi_bready);

  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      aw_w_ready <= 1'b0;
    end else begin
      aw_w_ready <= accept;  // One-cycle pulse
    end
  end

  // Byte offset is dropped from the captured index
  always_ff @(posedge S_AXI_ACLK) begin
    if (accept) begin
      awidx_q <= s_axi_awaddr[ADDR_WIDTH-1:ADDR_LSB];
    end
  end

  assign wr_strobe = aw_w_ready && s_axi_awvalid && s_axi_wvalid;
  assign wr_index  = awidx_q;
  assign wr_data   = s_axi_wdata;
  assign wr_strb   = s_axi_wstrb;

  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      bvalid_q <= 1'b0;
    end else if (wr_strobe) begin
      bvalid_q <= 1'b1;
    end else if (s_axi_bready) begin
      bvalid_q <= 1'b0;
    end
  end

  assign s_axi_awready = aw_w_ready;
  assign s_axi_wready  = aw_w_ready;
  assign s_axi_bvalid  = bvalid_q;
  assign s_axi_bresp   = RESP_OKAY;  // Register writes never fail

  // A stalled response is held and blocks new writes
  bvalid_hold: assert property (
    @(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid && !wr_strobe
  ) else $error("BVALID dropped or write accepted without BREADY");

endmodule

// File: regmap_pkg.sv
package regmap_pkg;

  // Byte offset bits below the register index, one 32-bit word per register
  localparam int ADDR_LSB = 2;

  // 7 address bits give 32 registers
  localparam int DEFAULT_ADDR_WIDTH = 7;

  // Register contents after reset
  localparam logic [31:0] REG_RESET_VALUE = 32'h0000_0000;

endpackage

// File: run_sim.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

# Build the simulation binary
verilator --binary --timing --assert --top-module tb_axil_regbank -f vlog.f

./obj_dir/Vtb_axil_regbank > sim.log 2>&1
cat sim.log

# The testbench prints the fail message on any error or timeout
if grep -q "Done: errors found" sim.log; then
  echo "Simulation FAILED"
  exit 1
fi

echo "Simulation PASSED"
exit 0

// File: tb_axil_regbank.sv
`timescale 1ns/1ps

module tb_axil_regbank;

  import axi_lite_pkg::*;

  localparam int ADDR_WIDTH     = 7;
  localparam int NUM_REGS       = 32;
  localparam int TIMEOUT_CYCLES = 100;

  logic                  S_AXI_ACLK = 1'b0;
  logic                  S_AXI_ARESETN;
  logic [ADDR_WIDTH-1:0] s_axi_awaddr;
  logic                  s_axi_awvalid;
  logic                  s_axi_awready;
  axil_data_t            s_axi_wdata;
  axil_strb_t            s_axi_wstrb;
  logic                  s_axi_wvalid;
  logic                  s_axi_wready;
  axil_resp_t            s_axi_bresp;
  logic                  s_axi_bvalid;
  logic                  s_axi_bready;
  logic [ADDR_WIDTH-1:0] s_axi_araddr;
  logic                  s_axi_arvalid;
  logic                  s_axi_arready;
  axil_data_t            s_axi_rdata;
  axil_resp_t            s_axi_rresp;
  logic                  s_axi_rvalid;
  logic                  s_axi_rready;

  axil_data_t model [NUM_REGS];  // Expected register contents
  int         errors;
  int         timeouts;
  integer     seed;

  axil_regbank #(.ADDR_WIDTH(ADDR_WIDTH)) u_axil_regbank (.*);

  always #10 S_AXI_ACLK = ~S_AXI_ACLK;

  function automatic logic [ADDR_WIDTH-1:0] byte_addr(input int idx, input int offset);
    int a;
    a = idx * 4 + offset;
    return a[ADDR_WIDTH-1:0];
  endfunction

  // Byte lanes with a set strobe take the new value
  function automatic axil_data_t merge_bytes(input axil_data_t old_val,
                                             input axil_data_t new_val,
                                             input axil_strb_t strb);
    axil_data_t res;
    res = old_val;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        res[b*8 +: 8] = new_val[b*8 +: 8];
      end
    end
    return res;
  endfunction

  task automatic check_data(input axil_data_t got, input axil_data_t exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t: %s gave %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_resp(input axil_resp_t got, input axil_resp_t exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t: %s gave response %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic report_timeout(input string what);
    timeouts++;
    $display("Timeout: the %s handshake never completed", what);
  endtask

  task automatic drive_write(input logic [ADDR_WIDTH-1:0] addr, input axil_data_t data,
                             input axil_strb_t strb);
    @(posedge S_AXI_ACLK);
    s_axi_awaddr  <= addr;
    s_axi_awvalid <= 1'b1;
    s_axi_wdata   <= data;
    s_axi_wstrb   <= strb;
    s_axi_wvalid  <= 1'b1;
  endtask

  task automatic wait_write_accept();
    int   cnt;
    logic ok;
    cnt = 0;
    do begin
      @(posedge S_AXI_ACLK);
      cnt++;
      ok = s_axi_awready && s_axi_wready;  // Levels just before this edge
    end while (!ok && cnt < TIMEOUT_CYCLES);
    if (!ok) begin
      report_timeout("AW/W");
    end
    s_axi_awvalid <= 1'b0;
    s_axi_wvalid  <= 1'b0;
  endtask

  task automatic wait_write_response(output axil_resp_t resp);
    int   cnt;
    logic ok;
    cnt = 0;
    do begin
      @(posedge S_AXI_ACLK);
      cnt++;
      ok = s_axi_bvalid;
    end while (!ok && cnt < TIMEOUT_CYCLES);
    if (!ok) begin
      report_timeout("B");
    end
    resp = s_axi_bresp;
  endtask

  task automatic drive_read(input logic [ADDR_WIDTH-1:0] addr);
    @(posedge S_AXI_ACLK);
    s_axi_araddr  <= addr;
    s_axi_arvalid <= 1'b1;
  endtask

  task automatic wait_read_accept();
    int   cnt;
    logic ok;
    cnt = 0;
    do begin
      @(posedge S_AXI_ACLK);
      cnt++;
      ok = s_axi_arready;
    end while (!ok && cnt < TIMEOUT_CYCLES);
    if (!ok) begin
      report_timeout("AR");
    end
    s_axi_arvalid <= 1'b0;
  endtask

  task automatic wait_read_data(output axil_data_t data, output axil_resp_t resp);
    int   cnt;
    logic ok;
    cnt = 0;
    do begin
      @(posedge S_AXI_ACLK);
      cnt++;
      ok = s_axi_rvalid;
    end while (!ok && cnt < TIMEOUT_CYCLES);
    if (!ok) begin
      report_timeout("R");
    end
    data = s_axi_rdata;
    resp = s_axi_rresp;
  endtask

  task automatic axil_write(input logic [ADDR_WIDTH-1:0] addr, input axil_data_t data,
                            input axil_strb_t strb);
    axil_resp_t resp;
    drive_write(addr, data, strb);
    wait_write_accept();
    wait_write_response(resp);
    check_resp(resp, RESP_OKAY, $sformatf("write to %h", addr));
  endtask

  task automatic axil_read(input logic [ADDR_WIDTH-1:0] addr, output axil_data_t data,
                           output axil_resp_t resp);
    drive_read(addr);
    wait_read_accept();
    wait_read_data(data, resp);
  endtask

  // Read one register and compare with the model
  task automatic read_and_compare(input int idx, input int offset);
    axil_data_t d;
    axil_resp_t r;
    axil_read(byte_addr(idx, offset), d, r);
    check_data(d, model[idx], $sformatf("read of reg %0d offset %0d", idx, offset));
    check_resp(r, RESP_OKAY, $sformatf("read of reg %0d", idx));
  endtask

  task automatic test_reset_values();
    for (int i = 0; i < NUM_REGS; i++) begin
      model[i] = '0;
      read_and_compare(i, 0);
    end
  endtask

  task automatic test_full_writes();
    axil_data_t d;
    for (int i = 0; i < NUM_REGS; i++) begin
      d = $random(seed);
      axil_write(byte_addr(i, 0), d, 4'hF);
      model[i] = d;
    end
    for (int i = 0; i < NUM_REGS; i++) begin
      read_and_compare(i, 0);
    end
  endtask

  task automatic test_partial_strobes();
    axil_data_t d;
    axil_strb_t strb;
    int         r;
    int         idx;
    for (int k = 0; k < 8; k++) begin
      idx  = k * 4 + 1;
      d    = $random(seed);
      r    = $random(seed);
      strb = r[3:0];
      axil_write(byte_addr(idx, 0), d, strb);
      model[idx] = merge_bytes(model[idx], d, strb);
      read_and_compare(idx, 0);
    end
  endtask

  task automatic test_unaligned();
    axil_data_t d;
    for (int off = 1; off < 4; off++) begin
      d = $random(seed);
      axil_write(byte_addr(5 + off, off), d, 4'hF);
      model[5 + off] = d;
      read_and_compare(5 + off, 3 - off);
      read_and_compare(5 + off, 0);
    end
  endtask

  task automatic test_write_backpressure();
    axil_data_t d1;
    axil_data_t d2;
    axil_resp_t resp;
    d1 = $random(seed);
    d2 = $random(seed);
    @(posedge S_AXI_ACLK);
    s_axi_bready <= 1'b0;
    drive_write(byte_addr(10, 0), d1, 4'hF);
    wait_write_accept();
    model[10] = d1;
    repeat (4) begin
      @(posedge S_AXI_ACLK);
      check_flag(s_axi_bvalid, 1'b1, "BVALID under back-pressure");
    end
    drive_write(byte_addr(11, 0), d2, 4'hF);  // Must wait for the stalled B
    repeat (6) begin
      @(posedge S_AXI_ACLK);
      check_flag(s_axi_awready, 1'b0, "AWREADY while B is stalled");
      check_flag(s_axi_bvalid, 1'b1, "BVALID under back-pressure");
    end
    check_resp(s_axi_bresp, RESP_OKAY, "stalled write");
    s_axi_bready <= 1'b1;
    wait_write_accept();
    wait_write_response(resp);
    check_resp(resp, RESP_OKAY, "second write");
    model[11] = d2;
    read_and_compare(10, 0);
    read_and_compare(11, 0);
  endtask

  task automatic test_read_backpressure();
    axil_data_t d;
    axil_resp_t r;
    @(posedge S_AXI_ACLK);
    s_axi_rready <= 1'b0;
    axil_read(byte_addr(10, 0), d, r);
    check_data(d, model[10], "stalled read of reg 10");
    repeat (4) begin
      @(posedge S_AXI_ACLK);
      check_flag(s_axi_rvalid, 1'b1, "RVALID under back-pressure");
      check_data(s_axi_rdata, model[10], "RDATA under back-pressure");
    end
    drive_read(byte_addr(11, 0));
    repeat (5) begin
      @(posedge S_AXI_ACLK);
      check_flag(s_axi_arready, 1'b0, "ARREADY while R is stalled");
      check_flag(s_axi_rvalid, 1'b1, "RVALID under back-pressure");
      check_data(s_axi_rdata, model[10], "RDATA under back-pressure");
    end
    s_axi_rready <= 1'b1;
    wait_read_accept();
    wait_read_data(d, r);
    check_data(d, model[11], "pending read of reg 11");
    check_resp(r, RESP_OKAY, "pending read of reg 11");
  endtask

  initial begin
    S_AXI_ARESETN <= 1'b0;
    s_axi_awaddr  <= '0;
    s_axi_awvalid <= 1'b0;
    s_axi_wdata   <= '0;
    s_axi_wstrb   <= '0;
    s_axi_wvalid  <= 1'b0;
    s_axi_bready  <= 1'b1;  // Masters take responses at once unless a test stalls
    s_axi_araddr  <= '0;
    s_axi_arvalid <= 1'b0;
    s_axi_rready  <= 1'b1;
    errors   = 0;
    timeouts = 0;
    seed     = 32'h7374;
    repeat (10) @(posedge S_AXI_ACLK);
    S_AXI_ARESETN <= 1'b1;
    repeat (2) @(posedge S_AXI_ACLK);
    test_reset_values();
    test_full_writes();
    test_partial_strobes();
    test_unaligned();
    test_write_backpressure();
    test_read_backpressure();
    repeat (2) @(posedge S_AXI_ACLK);
    $display("Finished with %0d value errors and %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// File: vlog.f
axi_lite_pkg.sv
regmap_pkg.sv
axil_write_channel.sv
axil_regfile.sv
axil_read_channel.sv
axil_regbank.sv
tb_axil_regbank.sv
